//--- mvm_params.svh
`ifndef MVM_PARAMS_SVH
`define MVM_PARAMS_SVH

// Datapath shape
`define MVM_LANES 4
`define MVM_LANE_W 32

// Storage depths
`define MVM_RF_DEPTH 16
`define MVM_INST_DEPTH 16
`define MVM_FIFO_DEPTH 16

// Engine latency from issue to result, in cycles
`define MVM_DPE_DELAY 4

// Output FIFO entries held back for results still in the engines
`define MVM_OUT_SLACK 8

// Rx sideband widths
`define MVM_META_W 8
`define MVM_USER_W 32

`endif

//--- mvm_data_pkg.sv
`default_nettype none

`include "mvm_params.svh"

package mvm_data_pkg;

	// One lane word and a full vector of lanes, lane 0 in the low bits
	typedef logic [`MVM_LANE_W-1:0] lane_t;
	typedef lane_t [`MVM_LANES-1:0] vec_t;

	// Shared by the register files and the accumulate memory
	typedef logic [$clog2(`MVM_RF_DEPTH)-1:0] rf_addr_t;

endpackage

`default_nettype wire

//--- mvm_isa_pkg.sv
`default_nettype none

`include "mvm_params.svh"

package mvm_isa_pkg;

	typedef logic [$clog2(`MVM_INST_DEPTH)-1:0] inst_addr_t;

	// rf_raddr doubles as the target of a jump
	typedef struct packed {
		mvm_data_pkg::rf_addr_t rf_raddr;
		mvm_data_pkg::rf_addr_t accum_raddr;
		logic last;
		logic release_en;
		logic accum_en;
		logic reduce;
		logic jump;
		logic en;
	} inst_t;

	// Destination of an rx beat, carried in the low bits of rx_tid
	typedef enum logic [1:0] {
		SID_INST   = 2'd0,
		SID_REDUCE = 2'd1,
		SID_INPUT  = 2'd2,
		SID_RF     = 2'd3
	} stream_id_t;

endpackage

`default_nettype wire

//--- mvm_fifo.sv
`default_nettype none

module mvm_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 16,
	parameter int SLACK = 1
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t idata,
	input  logic     pop,
	output payload_t odata,
	output logic     empty,
	output logic     full,
	output logic     almost_full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[tail] <= idata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
			end
			if (do_pop) begin
				head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	assign odata = mem[head];
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign almost_full = (DEPTH - int'(count)) < SLACK;

	// Producers and consumers are expected to honour the flags
	no_push_when_full: assert property (@(posedge clk) disable iff (rst) full |-> !push);
	no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) empty |-> !pop);

endmodule

`default_nettype wire

//--- mvm_ram.sv
`default_nettype none

module mvm_ram #(
	parameter type word_t = logic [31:0],
	parameter int DEPTH = 16,
	localparam int AW = $clog2(DEPTH)
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          wen,
	input  logic [AW-1:0] waddr,
	input  word_t         wdata,
	input  logic [AW-1:0] raddr,
	output word_t         rdata
);

	word_t mem [DEPTH];
	logic wen_q;
	logic [AW-1:0] waddr_q;
	word_t wdata_q;
	logic [AW-1:0] raddr_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			wen_q <= 1'b0;
		end else begin
			wen_q <= wen;
		end
	end

	// Write lands one clock after the strobe
	always_ff @(posedge clk) begin
		waddr_q <= waddr;
		wdata_q <= wdata;
		raddr_q <= raddr;
		if (wen_q) begin
			mem[waddr_q] <= wdata_q;
		end
	end

	assign rdata = mem[raddr_q];

endmodule

`default_nettype wire

//--- mvm_ingress.sv
`default_nettype none

`include "mvm_params.svh"

module mvm_ingress (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          rx_tvalid,
	input  mvm_data_pkg::vec_t            rx_tdata,
	input  logic [`MVM_META_W-1:0]        rx_tid,
	input  logic [`MVM_USER_W-1:0]        rx_tuser,
	input  logic                          reduce_full,
	input  logic                          input_full,
	output logic                          rx_tready,
	output logic                          inst_wen,
	output mvm_isa_pkg::inst_addr_t       inst_waddr,
	output mvm_isa_pkg::inst_t            inst_wdata,
	output logic                          reduce_push,
	output logic                          input_push,
	output mvm_data_pkg::vec_t            vec_data,
	output logic [`MVM_LANES-1:0]         rf_wen,
	output mvm_data_pkg::rf_addr_t        rf_waddr
);

	localparam int INST_AW = $bits(mvm_isa_pkg::inst_addr_t);
	localparam int RF_AW = $bits(mvm_data_pkg::rf_addr_t);

	mvm_isa_pkg::stream_id_t sid;
	logic sid_ok;
	logic xfer;

	assign sid = mvm_isa_pkg::stream_id_t'(rx_tid[1:0]);
	assign sid_ok = (rx_tid[`MVM_META_W-1:2] == '0);
	assign xfer = rx_tvalid && rx_tready;

	always_comb begin
		rx_tready = 1'b0;
		if (rx_tvalid && sid_ok) begin
			case (sid)
				mvm_isa_pkg::SID_REDUCE: rx_tready = !reduce_full;
				mvm_isa_pkg::SID_INPUT: rx_tready = !input_full;
				default: rx_tready = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_wen <= 1'b0;
			reduce_push <= 1'b0;
			input_push <= 1'b0;
			rf_wen <= '0;
		end else begin
			inst_wen <= xfer && (sid == mvm_isa_pkg::SID_INST);
			reduce_push <= xfer && (sid == mvm_isa_pkg::SID_REDUCE);
			input_push <= xfer && (sid == mvm_isa_pkg::SID_INPUT);
			// Lane write mask sits just above the row address
			rf_wen <= (xfer && (sid == mvm_isa_pkg::SID_RF)) ?
				rx_tuser[RF_AW +: `MVM_LANES] : '0;
		end
	end

	// One data register serves both FIFOs and the register files
	always_ff @(posedge clk) begin
		if (xfer) begin
			vec_data <= rx_tdata;
			inst_waddr <= rx_tuser[INST_AW-1:0];
			inst_wdata <= mvm_isa_pkg::inst_t'(rx_tdata[0][$bits(mvm_isa_pkg::inst_t)-1:0]);
			rf_waddr <= rx_tuser[RF_AW-1:0];
		end
	end

endmodule

`default_nettype wire

//--- mvm_sequencer.sv
`default_nettype none

module mvm_sequencer (
	input  logic                    clk,
	input  logic                    rst,
	input  mvm_isa_pkg::inst_t      inst,
	input  logic                    input_empty,
	input  logic                    reduce_empty,
	input  logic                    out_almost_full,
	input  mvm_data_pkg::vec_t      input_vec,
	input  mvm_data_pkg::vec_t      reduce_vec,
	output mvm_isa_pkg::inst_addr_t inst_raddr,
	output logic                    input_pop,
	output logic                    reduce_pop,
	output mvm_data_pkg::rf_addr_t  rf_raddr,
	output mvm_data_pkg::rf_addr_t  accum_raddr,
	output logic                    issue_valid,
	output logic                    issue_release,
	output logic                    issue_accum,
	output logic                    issue_reduce,
	output mvm_data_pkg::rf_addr_t  issue_accum_addr,
	output mvm_data_pkg::vec_t      operand_vec,
	output mvm_data_pkg::vec_t      reduce_operand
);

	mvm_isa_pkg::inst_addr_t pc;
	mvm_isa_pkg::inst_addr_t next_pc;
	logic issue;

	always_comb begin
		next_pc = pc;
		issue = 1'b0;
		if (inst.en) begin
			if (inst.jump) begin
				next_pc = mvm_isa_pkg::inst_addr_t'(inst.rf_raddr);
			end else if (!input_empty && (!inst.reduce || !reduce_empty) && !out_almost_full) begin
				issue = 1'b1;
				next_pc = pc + 1'b1;
			end
		end
	end

	// The memory registers next_pc, so inst always holds the word at pc
	assign inst_raddr = next_pc;
	assign rf_raddr = inst.rf_raddr;
	assign accum_raddr = inst.accum_raddr;
	assign input_pop = issue && inst.last;
	assign reduce_pop = issue && inst.reduce;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			issue_valid <= 1'b0;
		end else begin
			pc <= next_pc;
			issue_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			issue_release <= inst.release_en;
			issue_accum <= inst.accum_en;
			issue_reduce <= inst.reduce;
			issue_accum_addr <= inst.accum_raddr;
			operand_vec <= input_vec;
			reduce_operand <= reduce_vec;
		end
	end

	// An input vector stays at the head until an instruction with last pops it
	input_held_until_last: assert property (@(posedge clk) disable iff (rst)
		!input_empty && !input_pop |=> !input_empty);

endmodule

`default_nettype wire

//--- mvm_dpe.sv
`default_nettype none

module mvm_dpe (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issue_valid,
	input  logic                   issue_release,
	input  logic                   issue_accum,
	input  logic                   issue_reduce,
	input  mvm_data_pkg::rf_addr_t issue_accum_addr,
	input  mvm_data_pkg::vec_t     operand_vec,
	input  mvm_data_pkg::vec_t     row,
	input  mvm_data_pkg::lane_t    accum_in,
	input  mvm_data_pkg::lane_t    reduce_in,
	output mvm_data_pkg::lane_t    result,
	output logic                   result_valid,
	output logic                   result_release,
	output mvm_data_pkg::rf_addr_t result_addr
);

	localparam int LANES = $bits(mvm_data_pkg::vec_t) / $bits(mvm_data_pkg::lane_t);
	localparam int STAGES = 4;

	mvm_data_pkg::lane_t prod_q [LANES];
	mvm_data_pkg::lane_t prod_sum;
	mvm_data_pkg::lane_t dot_q;
	mvm_data_pkg::lane_t sum_q;
	mvm_data_pkg::lane_t accum_q1;
	mvm_data_pkg::lane_t accum_q2;
	mvm_data_pkg::lane_t reduce_q1;
	mvm_data_pkg::lane_t reduce_q2;
	mvm_data_pkg::lane_t reduce_q3;
	logic [STAGES-1:0] valid_sr;
	logic [STAGES-1:0] release_sr;
	mvm_data_pkg::rf_addr_t addr_sr [STAGES];

	// Sum of the registered lane products, all wrapping at 32 bits
	always_comb begin
		prod_sum = '0;
		for (int i = 0; i < LANES; i++) begin
			prod_sum = prod_sum + prod_q[i];
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES; i++) begin
			prod_q[i] <= operand_vec[i] * row[i];
		end
		// Disabled operands become zero so later stages add unconditionally
		accum_q1 <= issue_accum ? accum_in : '0;
		reduce_q1 <= issue_reduce ? reduce_in : '0;

		dot_q <= prod_sum;
		accum_q2 <= accum_q1;
		reduce_q2 <= reduce_q1;

		sum_q <= dot_q + accum_q2;
		reduce_q3 <= reduce_q2;

		result <= sum_q + reduce_q3;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[STAGES-2:0], issue_valid};
		end
	end

	always_ff @(posedge clk) begin
		release_sr <= {release_sr[STAGES-2:0], issue_release};
		addr_sr[0] <= issue_accum_addr;
		for (int s = 1; s < STAGES; s++) begin
			addr_sr[s] <= addr_sr[s-1];
		end
	end

	assign result_valid = valid_sr[STAGES-1];
	assign result_release = release_sr[STAGES-1];
	assign result_addr = addr_sr[STAGES-1];

endmodule

`default_nettype wire

//--- mvm.sv
`default_nettype none

`include "mvm_params.svh"

module mvm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rx_tvalid,
	input  mvm_data_pkg::vec_t     rx_tdata,
	input  logic [`MVM_META_W-1:0] rx_tid,
	input  logic [`MVM_USER_W-1:0] rx_tuser,
	output logic                   rx_tready,
	output logic                   tx_tvalid,
	output mvm_data_pkg::vec_t     tx_tdata,
	input  logic                   tx_tready
);

	// The push trails the rx accept by a clock, so rx backs off one entry early
	localparam int RX_SLACK = 2;

	logic inst_wen;
	mvm_isa_pkg::inst_addr_t inst_waddr;
	mvm_isa_pkg::inst_addr_t inst_raddr;
	mvm_isa_pkg::inst_t inst_wdata;
	mvm_isa_pkg::inst_t inst;
	logic reduce_push;
	logic input_push;
	mvm_data_pkg::vec_t vec_data;
	logic [`MVM_LANES-1:0] rf_wen;
	mvm_data_pkg::rf_addr_t rf_waddr;
	logic input_empty;
	logic input_afull;
	logic input_pop;
	mvm_data_pkg::vec_t input_head;
	logic reduce_empty;
	logic reduce_afull;
	logic reduce_pop;
	mvm_data_pkg::vec_t reduce_head;
	mvm_data_pkg::rf_addr_t rf_raddr;
	mvm_data_pkg::rf_addr_t accum_raddr;
	logic issue_valid;
	logic issue_release;
	logic issue_accum;
	logic issue_reduce;
	mvm_data_pkg::rf_addr_t issue_accum_addr;
	mvm_data_pkg::vec_t operand_vec;
	mvm_data_pkg::vec_t reduce_operand;
	mvm_data_pkg::vec_t rf_row [`MVM_LANES];
	mvm_data_pkg::vec_t accum_rdata;
	mvm_data_pkg::vec_t dpe_result;
	logic result_valid;
	logic result_release;
	mvm_data_pkg::rf_addr_t result_addr;
	logic out_empty;
	logic out_afull;
	logic out_pop;

	mvm_ingress ingress_inst (
		.clk(clk), .rst(rst), .rx_tvalid(rx_tvalid), .rx_tdata(rx_tdata), .rx_tid(rx_tid),
		.rx_tuser(rx_tuser), .reduce_full(reduce_afull), .input_full(input_afull),
		.rx_tready(rx_tready), .inst_wen(inst_wen), .inst_waddr(inst_waddr),
		.inst_wdata(inst_wdata), .reduce_push(reduce_push), .input_push(input_push),
		.vec_data(vec_data), .rf_wen(rf_wen), .rf_waddr(rf_waddr)
	);

	mvm_ram #(.word_t(mvm_isa_pkg::inst_t), .DEPTH(`MVM_INST_DEPTH)) inst_mem (
		.clk(clk), .rst(rst), .wen(inst_wen), .waddr(inst_waddr), .wdata(inst_wdata),
		.raddr(inst_raddr), .rdata(inst)
	);

	mvm_fifo #(.payload_t(mvm_data_pkg::vec_t), .DEPTH(`MVM_FIFO_DEPTH), .SLACK(RX_SLACK))
	input_fifo (
		.clk(clk), .rst(rst), .push(input_push), .idata(vec_data), .pop(input_pop),
		.odata(input_head), .empty(input_empty), .full(), .almost_full(input_afull)
	);

	mvm_fifo #(.payload_t(mvm_data_pkg::vec_t), .DEPTH(`MVM_FIFO_DEPTH), .SLACK(RX_SLACK))
	reduce_fifo (
		.clk(clk), .rst(rst), .push(reduce_push), .idata(vec_data), .pop(reduce_pop),
		.odata(reduce_head), .empty(reduce_empty), .full(), .almost_full(reduce_afull)
	);

	mvm_sequencer sequencer_inst (
		.clk(clk), .rst(rst), .inst(inst), .input_empty(input_empty),
		.reduce_empty(reduce_empty), .out_almost_full(out_afull), .input_vec(input_head),
		.reduce_vec(reduce_head), .inst_raddr(inst_raddr), .input_pop(input_pop),
		.reduce_pop(reduce_pop), .rf_raddr(rf_raddr), .accum_raddr(accum_raddr),
		.issue_valid(issue_valid), .issue_release(issue_release), .issue_accum(issue_accum),
		.issue_reduce(issue_reduce), .issue_accum_addr(issue_accum_addr),
		.operand_vec(operand_vec), .reduce_operand(reduce_operand)
	);

	// Every result is written back, released or not
	mvm_ram #(.word_t(mvm_data_pkg::vec_t), .DEPTH(`MVM_RF_DEPTH)) accum_mem (
		.clk(clk), .rst(rst), .wen(result_valid), .waddr(result_addr), .wdata(dpe_result),
		.raddr(accum_raddr), .rdata(accum_rdata)
	);

	for (genvar g = 0; g < `MVM_LANES; g++) begin : g_rf
		mvm_ram #(.word_t(mvm_data_pkg::vec_t), .DEPTH(`MVM_RF_DEPTH)) rf_inst (
			.clk(clk), .rst(rst), .wen(rf_wen[g]), .waddr(rf_waddr), .wdata(vec_data),
			.raddr(rf_raddr), .rdata(rf_row[g])
		);
	end

	// All engines run in lockstep, so lane 0 speaks for the group
	mvm_dpe dpe_lead (
		.clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_release(issue_release),
		.issue_accum(issue_accum), .issue_reduce(issue_reduce),
		.issue_accum_addr(issue_accum_addr), .operand_vec(operand_vec), .row(rf_row[0]),
		.accum_in(accum_rdata[0]), .reduce_in(reduce_operand[0]), .result(dpe_result[0]),
		.result_valid(result_valid), .result_release(result_release),
		.result_addr(result_addr)
	);

	for (genvar g = 1; g < `MVM_LANES; g++) begin : g_dpe
		mvm_dpe dpe_inst (
			.clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_release(issue_release),
			.issue_accum(issue_accum), .issue_reduce(issue_reduce),
			.issue_accum_addr(issue_accum_addr), .operand_vec(operand_vec), .row(rf_row[g]),
			.accum_in(accum_rdata[g]), .reduce_in(reduce_operand[g]), .result(dpe_result[g]),
			.result_valid(), .result_release(), .result_addr()
		);
	end

	mvm_fifo #(.payload_t(mvm_data_pkg::vec_t), .DEPTH(`MVM_FIFO_DEPTH), .SLACK(`MVM_OUT_SLACK))
	out_fifo (
		.clk(clk), .rst(rst), .push(result_valid && result_release), .idata(dpe_result),
		.pop(out_pop), .odata(tx_tdata), .empty(out_empty), .full(), .almost_full(out_afull)
	);

	assign tx_tvalid = !out_empty;
	assign out_pop = tx_tready && !out_empty;

	dpe_latency: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(issue_valid, `MVM_DPE_DELAY));

endmodule

`default_nettype wire

//--- tb_mvm_checker.sv
`default_nettype none

`include "mvm_params.svh"

module tb_mvm_checker (
	input logic                   clk,
	input logic                   rst,
	input logic                   rx_tvalid,
	input logic                   rx_tready,
	input logic [`MVM_META_W-1:0] rx_tid,
	input logic                   tx_tvalid,
	input logic                   tx_tready,
	input mvm_data_pkg::vec_t     tx_tdata
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [`MVM_META_W-1:0] ID_INPUT = `MVM_META_W'(mvm_isa_pkg::SID_INPUT);

	mvm_data_pkg::vec_t expected_q [$];
	int errors = 0;
	int matched = 0;
	int input_stalls = 0;

	task automatic push_expected(input mvm_data_pkg::vec_t v);
		expected_q.push_back(v);
	endtask

	function automatic int pending();
		return expected_q.size();
	endfunction

	task automatic require_input_stall();
		if (input_stalls == 0) begin
			$display("The input FIFO never held back rx beats for stream id 2");
			errors++;
		end
	endtask

	// Half a period before the edge, so these are the values that edge will see
	always @(negedge clk) begin
		mvm_data_pkg::vec_t exp_v;
		if (!rst) begin
			if (rx_tvalid && rx_tid == ID_INPUT && !rx_tready) begin
				input_stalls++;
			end
			if (tx_tvalid && expected_q.size() == 0) begin
				$display("tx_tvalid is high while no released result is outstanding");
				errors++;
			end else if (tx_tvalid && tx_tready) begin
				exp_v = expected_q.pop_front();
				if (tx_tdata !== exp_v) begin
					$display("CHECK FAILED tx_tdata: expected %h, got %h", exp_v, tx_tdata);
					errors++;
				end else begin
					matched++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_mvm.sv
`default_nettype none

`include "mvm_params.svh"

module tb_mvm;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROW_FIXED = 0;
	localparam int ROW_RANDOM = 1;
	localparam int ROW_DRAIN = 2;
	localparam int BEAT_TIMEOUT = 1000;
	localparam int DRAIN_TIMEOUT = 4000;
	localparam logic [7:0] ID_INST = 8'(mvm_isa_pkg::SID_INST);
	localparam logic [7:0] ID_REDUCE = 8'(mvm_isa_pkg::SID_REDUCE);
	localparam logic [7:0] ID_INPUT = 8'(mvm_isa_pkg::SID_INPUT);
	localparam logic [7:0] ID_RF = 8'(mvm_isa_pkg::SID_RF);
	// Flag bits in instruction order, last down to en
	localparam logic [5:0] OP_LAST = 6'b100000;
	localparam logic [5:0] OP_RELEASE = 6'b010000;
	localparam logic [5:0] OP_ACCUM = 6'b001000;
	localparam logic [5:0] OP_REDUCE = 6'b000100;
	localparam logic [5:0] OP_JUMP = 6'b000010;
	localparam logic [5:0] OP_EN = 6'b000001;

	typedef struct {
		int kind;
		logic [7:0] sid;
		logic [31:0] user;
		mvm_data_pkg::vec_t data;
		int count;
		bit slow_tx;
	} row_t;

	logic clk;
	logic rst;
	logic rx_tvalid;
	mvm_data_pkg::vec_t rx_tdata;
	logic [`MVM_META_W-1:0] rx_tid;
	logic [`MVM_USER_W-1:0] rx_tuser;
	logic rx_tready;
	logic tx_tvalid;
	mvm_data_pkg::vec_t tx_tdata;
	logic tx_tready;

	row_t table_q [$];
	logic [31:0] rng_state = 32'hff52c9df;
	bit slow_tx = 1'b0;
	int cycle = 0;
	int timeouts = 0;

	// Reference state of the engine
	mvm_isa_pkg::inst_t prog_m [`MVM_INST_DEPTH];
	mvm_data_pkg::vec_t rf_m [`MVM_LANES][`MVM_RF_DEPTH];
	mvm_data_pkg::vec_t accum_m [`MVM_RF_DEPTH];
	mvm_data_pkg::vec_t in_q [$];
	mvm_data_pkg::vec_t red_q [$];
	mvm_isa_pkg::inst_addr_t pc_m = '0;

	mvm mvm_inst (
		.clk(clk), .rst(rst), .rx_tvalid(rx_tvalid), .rx_tdata(rx_tdata), .rx_tid(rx_tid),
		.rx_tuser(rx_tuser), .rx_tready(rx_tready), .tx_tvalid(tx_tvalid),
		.tx_tdata(tx_tdata), .tx_tready(tx_tready)
	);

	tb_mvm_checker checker_inst (
		.clk(clk), .rst(rst), .rx_tvalid(rx_tvalid), .rx_tready(rx_tready), .rx_tid(rx_tid),
		.tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tdata(tx_tdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// When slow, tx_tready is high only one cycle in twenty
	initial begin
		tx_tready = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			cycle++;
			tx_tready = !slow_tx || (cycle % 20 == 0);
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic mvm_data_pkg::lane_t dot(input mvm_data_pkg::vec_t a,
			input mvm_data_pkg::vec_t b);
		mvm_data_pkg::lane_t sum;
		sum = '0;
		for (int j = 0; j < `MVM_LANES; j++) begin
			sum = sum + a[j] * b[j];
		end
		return sum;
	endfunction

	function automatic void add_row(input int kind, input logic [7:0] sid,
			input logic [31:0] user, input mvm_data_pkg::vec_t data, input int count,
			input bit slow);
		row_t r;
		r.kind = kind;
		r.sid = sid;
		r.user = user;
		r.data = data;
		r.count = count;
		r.slow_tx = slow;
		table_q.push_back(r);
	endfunction

	function automatic void load_inst(input mvm_isa_pkg::inst_addr_t addr,
			input mvm_data_pkg::rf_addr_t rf, input mvm_data_pkg::rf_addr_t acc,
			input logic [5:0] ops);
		mvm_isa_pkg::inst_t ins;
		mvm_data_pkg::vec_t word;
		ins = {rf, acc, ops | OP_EN};
		word = '0;
		word[0][$bits(mvm_isa_pkg::inst_t)-1:0] = ins;
		add_row(ROW_FIXED, ID_INST, 32'(addr), word, 1, 1'b0);
	endfunction

	function automatic void random_beats(input logic [7:0] sid, input logic [31:0] user,
			input int count, input bit slow);
		add_row(ROW_RANDOM, sid, user, '0, count, slow);
	endfunction

	function automatic void drain_point(input bit slow);
		add_row(ROW_DRAIN, 8'd0, 32'd0, '0, 0, slow);
	endfunction

	// Every phase ends with pc parked at 0 and the input FIFO empty, so reloading is safe
	task automatic build_table();
		// Rows 0 to 3 in every lane, mask in bits 7:4 and row in bits 3:0
		random_beats(ID_RF, 32'h0000_00f0, 4, 1'b0);
		load_inst(4'd0, 4'd0, 4'd0, OP_LAST | OP_RELEASE);
		load_inst(4'd1, 4'd0, 4'd0, OP_JUMP);
		random_beats(ID_INPUT, 32'd0, 6, 1'b0);
		drain_point(1'b0);
		// Five jumps keep the accumulate read behind the first write-back
		load_inst(4'd0, 4'd2, 4'd5, 6'b0);
		for (int k = 1; k < 6; k++) begin
			load_inst(4'(k), 4'(k + 1), 4'd0, OP_JUMP);
		end
		load_inst(4'd6, 4'd3, 4'd5, OP_LAST | OP_RELEASE | OP_ACCUM);
		load_inst(4'd7, 4'd0, 4'd0, OP_JUMP);
		random_beats(ID_INPUT, 32'd0, 4, 1'b0);
		drain_point(1'b0);
		load_inst(4'd0, 4'd1, 4'd6, OP_LAST | OP_RELEASE | OP_REDUCE);
		load_inst(4'd1, 4'd0, 4'd0, OP_JUMP);
		random_beats(ID_INPUT, 32'd0, 4, 1'b0);
		random_beats(ID_REDUCE, 32'd0, 4, 1'b0);
		drain_point(1'b0);
		// Row 0 rewritten in lanes 0 and 2 only
		random_beats(ID_RF, 32'h0000_0050, 1, 1'b0);
		load_inst(4'd0, 4'd0, 4'd0, OP_LAST | OP_RELEASE);
		load_inst(4'd1, 4'd0, 4'd0, OP_JUMP);
		random_beats(ID_INPUT, 32'd0, 4, 1'b0);
		drain_point(1'b0);
		random_beats(ID_INPUT, 32'd0, 32, 1'b1);
		drain_point(1'b1);
	endtask

	// Runs the program until it must wait for data
	task automatic advance_program();
		mvm_isa_pkg::inst_t ins;
		mvm_data_pkg::vec_t res;
		bit stalled;
		int steps;
		stalled = 1'b0;
		steps = 0;
		while (!stalled && steps < 64) begin
			ins = prog_m[pc_m];
			steps++;
			if (!ins.en) begin
				stalled = 1'b1;
			end else if (ins.jump) begin
				pc_m = ins.rf_raddr;
			end else if (in_q.size() > 0 && (!ins.reduce || red_q.size() > 0)) begin
				for (int g = 0; g < `MVM_LANES; g++) begin
					res[g] = dot(in_q[0], rf_m[g][ins.rf_raddr]);
					if (ins.accum_en) begin
						res[g] = res[g] + accum_m[ins.accum_raddr][g];
					end
					if (ins.reduce) begin
						res[g] = res[g] + red_q[0][g];
					end
				end
				accum_m[ins.accum_raddr] = res;
				if (ins.release_en) begin
					checker_inst.push_expected(res);
				end
				if (ins.reduce) begin
					void'(red_q.pop_front());
				end
				if (ins.last) begin
					void'(in_q.pop_front());
				end
				pc_m = pc_m + 1'b1;
			end else begin
				stalled = 1'b1;
			end
		end
	endtask

	task automatic record_beat(input logic [7:0] sid, input logic [31:0] user,
			input mvm_data_pkg::vec_t data);
		case (sid)
			ID_INST: prog_m[user[3:0]] = data[0][$bits(mvm_isa_pkg::inst_t)-1:0];
			ID_REDUCE: red_q.push_back(data);
			ID_INPUT: in_q.push_back(data);
			ID_RF: begin
				for (int g = 0; g < `MVM_LANES; g++) begin
					if (user[4 + g]) begin
						rf_m[g][user[3:0]] = data;
					end
				end
			end
			default: ;
		endcase
		advance_program();
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic send_beat(input logic [7:0] sid, input logic [31:0] user,
			input mvm_data_pkg::vec_t data);
		int waited;
		bit accepted;
		waited = 0;
		accepted = 1'b0;
		rx_tvalid = 1'b1;
		rx_tid = sid;
		rx_tuser = user;
		rx_tdata = data;
		while (!accepted && waited < BEAT_TIMEOUT) begin
			@(negedge clk);
			accepted = rx_tready;
			@(posedge clk);
			#1;
			waited++;
		end
		rx_tvalid = 1'b0;
		if (accepted) begin
			record_beat(sid, user, data);
		end else begin
			$display("Timed out waiting for rx_tready on stream id %0d", sid);
			timeouts++;
		end
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (checker_inst.pending() != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (checker_inst.pending() != 0) begin
			$display("Timed out with %0d results still missing on tx", checker_inst.pending());
			timeouts++;
		end
	endtask

	initial begin
		mvm_data_pkg::vec_t data;
		rst = 1'b1;
		rx_tvalid = 1'b0;
		rx_tdata = '0;
		rx_tid = '0;
		rx_tuser = '0;
		foreach (prog_m[a]) begin
			prog_m[a] = '0;
		end
		build_table();
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		foreach (table_q[i]) begin
			slow_tx = table_q[i].slow_tx;
			if (table_q[i].kind == ROW_DRAIN) begin
				wait_for_drain();
			end else begin
				for (int k = 0; k < table_q[i].count; k++) begin
					data = table_q[i].data;
					if (table_q[i].kind == ROW_RANDOM) begin
						for (int g = 0; g < `MVM_LANES; g++) begin
							data[g] = next_random();
						end
					end
					send_beat(table_q[i].sid, table_q[i].user + 32'(k), data);
				end
			end
		end

		// Stray tx beats after the last result would still be caught here
		repeat (20) @(posedge clk);
		checker_inst.require_input_stall();
		$display("Errors: %0d from checks, %0d timeouts; %0d results matched",
			checker_inst.errors, timeouts, checker_inst.matched);
		if (checker_inst.errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mvm.f
+incdir+.
mvm_data_pkg.sv
mvm_isa_pkg.sv
mvm_fifo.sv
mvm_ram.sv
mvm_ingress.sv
mvm_sequencer.sv
mvm_dpe.sv
mvm.sv
tb_mvm_checker.sv
tb_mvm.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f mvm.f \
		--top-module tb_mvm -Mdir obj_dir -o sim_mvm
	./obj_dir/sim_mvm | tee $(LOG)
	grep -qx "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
